//--- design/ring_packet_pkg.sv
package ring_packet_pkg;

    // ----------------------------------------
    // Packet layout
    // ----------------------------------------
    localparam int PACKET_WIDTH = 64;
    localparam int DIR_BIT = 62;
    localparam int HOP_LSB = 48;
    localparam int HOP_WIDTH = 8;

    typedef logic [PACKET_WIDTH-1:0] packet_t;
    typedef logic [HOP_WIDTH-1:0] hop_t;

    // Ring direction carried in the direction bit
    typedef enum logic {
        DIR_CW  = 1'b0,
        DIR_CCW = 1'b1
    } dir_e;

    // ----------------------------------------
    // Field access
    // ----------------------------------------
    function automatic hop_t get_hop(packet_t packet);
        return packet[HOP_LSB +: HOP_WIDTH];
    endfunction

    function automatic dir_e get_dir(packet_t packet);
        return dir_e'(packet[DIR_BIT]);
    endfunction

    // One hop consumed per transfer, all other bits kept
    function automatic packet_t shift_hop(packet_t packet);
        packet_t shifted;
        shifted = packet;
        shifted[HOP_LSB +: HOP_WIDTH] = get_hop(packet) >> 1;
        return shifted;
    endfunction

endpackage

//--- design/router_cfg_pkg.sv
package router_cfg_pkg;

    // ----------------------------------------
    // Ports of one ring node
    // ----------------------------------------
    typedef enum logic [1:0] {
        PORT_CW  = 2'd0,
        PORT_CCW = 2'd1,
        PORT_PE  = 2'd2
    } port_e;

    localparam int NUM_PORTS = 3;

    // ----------------------------------------
    // Virtual channels, numbered like polarity
    // ----------------------------------------
    typedef enum logic {
        VC_EVEN = 1'b0,
        VC_ODD  = 1'b1
    } vc_e;

    localparam int NUM_VCS = 2;

    // External ports work on the VC of the current polarity
    function automatic vc_e port_vc(logic polarity);
        return vc_e'(polarity);
    endfunction

    // The switch works on the other one
    function automatic vc_e switch_vc(logic polarity);
        return vc_e'(~polarity);
    endfunction

endpackage

//--- design/port_link_if.sv
interface port_link_if;

    // Head of the input buffer, transfer VC
    ring_packet_pkg::packet_t head_packet;
    logic head_valid;
    logic head_take;

    // Fill side of the output buffer, transfer VC
    ring_packet_pkg::packet_t fill_packet;
    logic fill_load;
    logic fill_room;

    modport ingress (
        output head_packet,
        output head_valid,
        input  head_take
    );

    modport egress (
        input  fill_packet,
        input  fill_load,
        output fill_room
    );

    modport switch (
        input  head_packet,
        input  head_valid,
        output head_take,
        output fill_packet,
        output fill_load,
        input  fill_room
    );

endinterface

//--- design/vc_buffer.sv
module vc_buffer #(
    parameter bit INGRESS = 1'b1
) (
    input  logic clk,
    input  logic reset,
    input  logic polarity,
    input  ring_packet_pkg::packet_t ext_packet_in,
    output ring_packet_pkg::packet_t ext_packet_out,
    input  logic ext_strobe,
    output logic ext_ready,
    port_link_if link
);
    import ring_packet_pkg::*;
    import router_cfg_pkg::*;

    packet_t slot [NUM_VCS];
    logic [NUM_VCS-1:0] full;

    vc_e ext_vc;
    vc_e int_vc;

    logic wr_en;
    vc_e wr_vc;
    packet_t wr_data;
    logic clr_en;
    vc_e clr_vc;

    assign ext_vc = port_vc(polarity);
    assign int_vc = switch_vc(polarity);

    // Slot of the external VC, the output data on an egress port
    assign ext_packet_out = slot[ext_vc];

    // ----------------------------------------
    // Side selection
    // ----------------------------------------
    generate
        if (INGRESS) begin : g_ingress
            // Holds ri low until the first edge after reset
            logic armed;

            always_ff @(posedge clk) begin
                if (reset) begin
                    armed <= 1'b0;
                end else begin
                    armed <= 1'b1;
                end
            end

            // Sender writes the external VC, switch drains the other
            assign ext_ready = armed && !full[ext_vc];
            assign wr_en = ext_strobe && ext_ready;
            assign wr_vc = ext_vc;
            assign wr_data = ext_packet_in;

            assign link.head_packet = slot[int_vc];
            assign link.head_valid = full[int_vc];
            assign clr_en = link.head_take;
            assign clr_vc = int_vc;
        end else begin : g_egress
            // Here ext_strobe is the receiver's ready and ext_ready is so
            assign link.fill_room = !full[int_vc];
            assign wr_en = link.fill_load;
            assign wr_vc = int_vc;
            assign wr_data = link.fill_packet;

            assign ext_ready = full[ext_vc];
            assign clr_en = ext_strobe && ext_ready;
            assign clr_vc = ext_vc;
        end
    endgenerate

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            full <= '0;
        end else begin
            // Write and clear always hit different VCs
            if (wr_en) begin
                full[wr_vc] <= 1'b1;
            end
            if (clr_en) begin
                full[clr_vc] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            slot[wr_vc] <= wr_data;
        end
    end

    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset) wr_en |-> !full[wr_vc]
    ) else $error("write into a full VC slot");

endmodule

//--- design/route_arbiter.sv
module route_arbiter (
    input  logic clk,
    input  logic reset,
    input  logic polarity,
    input  logic req_through,
    input  logic req_inject,
    output logic grant_through,
    output logic grant_inject
);
    import router_cfg_pkg::*;

    // One priority bit per VC, the phases never share state
    logic [NUM_VCS-1:0] favor_inject;
    vc_e vc;

    assign vc = switch_vc(polarity);

    // Lone requester always wins, a tie goes to the favored side
    assign grant_through = req_through && (!req_inject || !favor_inject[vc]);
    assign grant_inject = req_inject && (!req_through || favor_inject[vc]);

    // Last winner drops to low priority
    always_ff @(posedge clk) begin
        if (reset) begin
            favor_inject <= '0;
        end else if (grant_through || grant_inject) begin
            favor_inject[vc] <= grant_through;
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_one_grant: assert property (
        @(posedge clk) disable iff (reset) !(grant_through && grant_inject)
    ) else $error("both requesters granted");

    // Same VC returns two cycles later and the loser of a tie goes first
    a_alternate: assert property (
        @(posedge clk) disable iff (reset)
        (req_through && req_inject && grant_through) ##2 (req_through && req_inject)
        |-> grant_inject
    ) else $error("tie not alternated within a VC");

endmodule

//--- design/route_switch.sv
module route_switch (
    input  logic clk,
    input  logic reset,
    input  logic polarity,
    port_link_if.switch cw_link,
    port_link_if.switch ccw_link,
    port_link_if.switch pe_link
);
    import ring_packet_pkg::*;
    import router_cfg_pkg::*;

    packet_t head [NUM_PORTS];
    logic [NUM_PORTS-1:0] head_valid;
    logic [NUM_PORTS-1:0] room;
    port_e target [NUM_PORTS];
    logic [NUM_PORTS-1:0] req;

    // Grants named by output, then by requester role
    logic cw_out_grant_through;
    logic cw_out_grant_inject;
    logic ccw_out_grant_through;
    logic ccw_out_grant_inject;
    logic pe_out_grant_through;
    logic pe_out_grant_inject;

    // ----------------------------------------
    // Link gather
    // ----------------------------------------
    assign head[PORT_CW] = cw_link.head_packet;
    assign head[PORT_CCW] = ccw_link.head_packet;
    assign head[PORT_PE] = pe_link.head_packet;

    assign head_valid[PORT_CW] = cw_link.head_valid;
    assign head_valid[PORT_CCW] = ccw_link.head_valid;
    assign head_valid[PORT_PE] = pe_link.head_valid;

    assign room[PORT_CW] = cw_link.fill_room;
    assign room[PORT_CCW] = ccw_link.fill_room;
    assign room[PORT_PE] = pe_link.fill_room;

    // ----------------------------------------
    // Route decode
    // ----------------------------------------
    always_comb begin
        // Ring packets keep going while hop LSB is set, else drop to pe
        target[PORT_CW] = head[PORT_CW][HOP_LSB] ? PORT_CW : PORT_PE;
        target[PORT_CCW] = head[PORT_CCW][HOP_LSB] ? PORT_CCW : PORT_PE;
        target[PORT_PE] = (get_dir(head[PORT_PE]) == DIR_CW) ? PORT_CW : PORT_CCW;

        // Request only when the target slot can take it
        for (int i = 0; i < NUM_PORTS; i++) begin
            req[i] = head_valid[i] && room[target[i]];
        end
    end

    // ----------------------------------------
    // Output arbiters
    // ----------------------------------------
    route_arbiter cw_arbiter (
        .clk           (clk),
        .reset         (reset),
        .polarity      (polarity),
        .req_through   (req[PORT_CW] && target[PORT_CW] == PORT_CW),
        .req_inject    (req[PORT_PE] && target[PORT_PE] == PORT_CW),
        .grant_through (cw_out_grant_through),
        .grant_inject  (cw_out_grant_inject)
    );

    route_arbiter ccw_arbiter (
        .clk           (clk),
        .reset         (reset),
        .polarity      (polarity),
        .req_through   (req[PORT_CCW] && target[PORT_CCW] == PORT_CCW),
        .req_inject    (req[PORT_PE] && target[PORT_PE] == PORT_CCW),
        .grant_through (ccw_out_grant_through),
        .grant_inject  (ccw_out_grant_inject)
    );

    // pe output: cw input on the through side, ccw input on the inject side
    route_arbiter pe_arbiter (
        .clk           (clk),
        .reset         (reset),
        .polarity      (polarity),
        .req_through   (req[PORT_CW] && target[PORT_CW] == PORT_PE),
        .req_inject    (req[PORT_CCW] && target[PORT_CCW] == PORT_PE),
        .grant_through (pe_out_grant_through),
        .grant_inject  (pe_out_grant_inject)
    );

    // ----------------------------------------
    // Transfer control
    // ----------------------------------------
    // Each input targets one output, so at most one grant per input
    assign cw_link.head_take = cw_out_grant_through || pe_out_grant_through;
    assign ccw_link.head_take = ccw_out_grant_through || pe_out_grant_inject;
    assign pe_link.head_take = cw_out_grant_inject || ccw_out_grant_inject;

    assign cw_link.fill_load = cw_out_grant_through || cw_out_grant_inject;
    assign ccw_link.fill_load = ccw_out_grant_through || ccw_out_grant_inject;
    assign pe_link.fill_load = pe_out_grant_through || pe_out_grant_inject;

    assign cw_link.fill_packet =
        shift_hop(cw_out_grant_inject ? head[PORT_PE] : head[PORT_CW]);
    assign ccw_link.fill_packet =
        shift_hop(ccw_out_grant_inject ? head[PORT_PE] : head[PORT_CCW]);
    assign pe_link.fill_packet =
        shift_hop(pe_out_grant_inject ? head[PORT_CCW] : head[PORT_CW]);

endmodule

//--- design/ring_router.sv
module ring_router (
    input  logic clk,
    input  logic reset,
    input  ring_packet_pkg::packet_t cwdi,
    input  logic cwsi,
    output logic cwri,
    input  ring_packet_pkg::packet_t ccwdi,
    input  logic ccwsi,
    output logic ccwri,
    input  ring_packet_pkg::packet_t pedi,
    input  logic pesi,
    output logic peri,
    output ring_packet_pkg::packet_t cwdo,
    output logic cwso,
    input  logic cwro,
    output ring_packet_pkg::packet_t ccwdo,
    output logic ccwso,
    input  logic ccwro,
    output ring_packet_pkg::packet_t pedo,
    output logic peso,
    input  logic pero,
    output logic polarity
);
    import router_cfg_pkg::*;

    port_link_if cw_link ();
    port_link_if ccw_link ();
    port_link_if pe_link ();

    // Even VC faces the ports in the first cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            polarity <= VC_EVEN;
        end else begin
            polarity <= ~polarity;
        end
    end

    // ----------------------------------------
    // Input buffers
    // ----------------------------------------
    vc_buffer #(.INGRESS(1'b1)) cw_in_buffer (
        .clk(clk), .reset(reset), .polarity(polarity),
        .ext_packet_in(cwdi), .ext_packet_out(),
        .ext_strobe(cwsi), .ext_ready(cwri),
        .link(cw_link.ingress)
    );

    vc_buffer #(.INGRESS(1'b1)) ccw_in_buffer (
        .clk(clk), .reset(reset), .polarity(polarity),
        .ext_packet_in(ccwdi), .ext_packet_out(),
        .ext_strobe(ccwsi), .ext_ready(ccwri),
        .link(ccw_link.ingress)
    );

    vc_buffer #(.INGRESS(1'b1)) pe_in_buffer (
        .clk(clk), .reset(reset), .polarity(polarity),
        .ext_packet_in(pedi), .ext_packet_out(),
        .ext_strobe(pesi), .ext_ready(peri),
        .link(pe_link.ingress)
    );

    // ----------------------------------------
    // Output buffers
    // ----------------------------------------
    // Receiver ready goes in on ext_strobe, so comes back on ext_ready
    vc_buffer #(.INGRESS(1'b0)) cw_out_buffer (
        .clk(clk), .reset(reset), .polarity(polarity),
        .ext_packet_in('0), .ext_packet_out(cwdo),
        .ext_strobe(cwro), .ext_ready(cwso),
        .link(cw_link.egress)
    );

    vc_buffer #(.INGRESS(1'b0)) ccw_out_buffer (
        .clk(clk), .reset(reset), .polarity(polarity),
        .ext_packet_in('0), .ext_packet_out(ccwdo),
        .ext_strobe(ccwro), .ext_ready(ccwso),
        .link(ccw_link.egress)
    );

    vc_buffer #(.INGRESS(1'b0)) pe_out_buffer (
        .clk(clk), .reset(reset), .polarity(polarity),
        .ext_packet_in('0), .ext_packet_out(pedo),
        .ext_strobe(pero), .ext_ready(peso),
        .link(pe_link.egress)
    );

    route_switch switch_inst (
        .clk      (clk),
        .reset    (reset),
        .polarity (polarity),
        .cw_link  (cw_link.switch),
        .ccw_link (ccw_link.switch),
        .pe_link  (pe_link.switch)
    );

    // Buffers and arbiters all rely on a strict even/odd cadence
    a_polarity_toggle: assert property (
        @(posedge clk) disable iff (reset) !$past(reset) |-> polarity != $past(polarity)
    ) else $error("polarity did not alternate");

endmodule

//--- verification/router_model.svh
`ifndef ROUTER_MODEL_SVH
`define ROUTER_MODEL_SVH

// ----------------------------------------
// Expected traffic
// ----------------------------------------
typedef struct {
    packet_t pkt;
    int unsigned accept_cycle;
} expect_t;

// One list per output, packets already in their outgoing form
expect_t expect_q [NUM_PORTS][$];

// ----------------------------------------
// Routing rules
// ----------------------------------------
function automatic int route_of(int src, packet_t pkt);
    // Injected packets pick a ring by the direction bit
    if (src == PORT_PE) begin
        return (pkt[DIR_BIT] == DIR_CCW) ? PORT_CCW : PORT_CW;
    end
    // Ring packets stay on the ring while hops remain
    return pkt[HOP_LSB] ? src : PORT_PE;
endfunction

// Hop field moves down one bit, a zero enters at the top
function automatic packet_t hop_consumed(packet_t pkt);
    packet_t result;
    result = pkt;
    for (int i = 0; i < HOP_WIDTH; i++) begin
        if (i == HOP_WIDTH - 1) begin
            result[HOP_LSB + i] = 1'b0;
        end else begin
            result[HOP_LSB + i] = pkt[HOP_LSB + i + 1];
        end
    end
    return result;
endfunction

function automatic void record_accept(int src, packet_t pkt, int unsigned cycle);
    expect_t entry;
    entry.pkt = hop_consumed(pkt);
    entry.accept_cycle = cycle;
    expect_q[route_of(src, pkt)].push_back(entry);
endfunction

// Removes the first matching entry, order within a list is not fixed
function automatic bit take_expected(int dst, packet_t pkt, output int unsigned accept_cycle);
    accept_cycle = 0;
    foreach (expect_q[dst][i]) begin
        if (expect_q[dst][i].pkt === pkt) begin
            accept_cycle = expect_q[dst][i].accept_cycle;
            expect_q[dst].delete(i);
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic int pending_count();
    int total;
    total = 0;
    foreach (expect_q[p]) begin
        total += expect_q[p].size();
    end
    return total;
endfunction

`endif

//--- verification/ring_router_tb.sv
module ring_router_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import ring_packet_pkg::*;
    import router_cfg_pkg::*;

    logic clk = 1'b0;
    logic reset;
    logic polarity;
    packet_t di_drv [NUM_PORTS];
    packet_t do_obs [NUM_PORTS];
    logic [NUM_PORTS-1:0] si_drv;
    logic [NUM_PORTS-1:0] ri_obs;
    logic [NUM_PORTS-1:0] so_obs;
    logic [NUM_PORTS-1:0] ro_drv;

    // Stimulus rates in quarters where 4 means every cycle
    int gen_rate [NUM_PORTS];
    int ro_rate [NUM_PORTS];
    integer seed = 32'h2e63;

    int unsigned cycle;
    int error_count;
    int test_count;
    int failed_tests;
    int consumed [NUM_PORTS];
    string port_name [NUM_PORTS] = '{"cw", "ccw", "pe"};

    // Output state two cycles back when the same VC faced the port
    logic [NUM_PORTS-1:0] so_past [2];
    logic [NUM_PORTS-1:0] ro_past [2];
    packet_t do_past [2][NUM_PORTS];

    `include "router_model.svh"

    ring_router ring_router_inst (
        .clk(clk), .reset(reset), .polarity(polarity),
        .cwdi(di_drv[PORT_CW]), .cwsi(si_drv[PORT_CW]), .cwri(ri_obs[PORT_CW]),
        .ccwdi(di_drv[PORT_CCW]), .ccwsi(si_drv[PORT_CCW]), .ccwri(ri_obs[PORT_CCW]),
        .pedi(di_drv[PORT_PE]), .pesi(si_drv[PORT_PE]), .peri(ri_obs[PORT_PE]),
        .cwdo(do_obs[PORT_CW]), .cwso(so_obs[PORT_CW]), .cwro(ro_drv[PORT_CW]),
        .ccwdo(do_obs[PORT_CCW]), .ccwso(so_obs[PORT_CCW]), .ccwro(ro_drv[PORT_CCW]),
        .pedo(do_obs[PORT_PE]), .peso(so_obs[PORT_PE]), .pero(ro_drv[PORT_PE])
    );

    always #20 clk = ~clk;

    // ----------------------------------------
    // Stimulus on the falling edge
    // ----------------------------------------
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            si_drv[p] = ($random(seed) & 3) < gen_rate[p];
            di_drv[p] = {$random(seed), $random(seed)};
            ro_drv[p] = ($random(seed) & 3) < ro_rate[p];
        end
    end

    task automatic verify_level(string name, logic got, logic expected);
        assert (got === expected) else begin
            $display("mismatch %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic compare_packet(string name, packet_t got, packet_t expected);
        assert (got === expected) else begin
            $display("mismatch %s got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic match_consumed(int p);
        bit found;
        int unsigned accepted_at;
        found = take_expected(p, do_obs[p], accepted_at);
        assert (found) else begin
            if (expect_q[p].size() > 0) begin
                $display("mismatch %sdo got %h expected %h",
                    port_name[p], do_obs[p], expect_q[p][0].pkt);
            end else begin
                $display("%sdo delivered a packet that no input sent", port_name[p]);
            end
            error_count++;
        end
        if (found) begin
            consumed[p]++;
            assert (cycle - accepted_at >= 2) else begin
                $display("%sdo delivered a packet %0d cycles after acceptance, below two",
                    port_name[p], cycle - accepted_at);
                error_count++;
            end
        end
    endtask

    // ----------------------------------------
    // Monitor on the rising edge
    // ----------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            cycle = 0;
            so_past = '{default: '0};
            ro_past = '{default: '0};
        end else begin
            cycle++;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (si_drv[p] && ri_obs[p]) begin
                    record_accept(p, di_drv[p], cycle);
                end
                if (so_obs[p] && ro_drv[p]) begin
                    match_consumed(p);
                end
                // A stalled output keeps its packet until the receiver takes it
                if (so_past[1][p] && !ro_past[1][p]) begin
                    verify_level({port_name[p], "so"}, so_obs[p], 1'b1);
                    compare_packet({port_name[p], "do"}, do_obs[p], do_past[1][p]);
                end
            end
            so_past[1] = so_past[0];
            so_past[0] = so_obs;
            ro_past[1] = ro_past[0];
            ro_past[0] = ro_drv;
            do_past[1] = do_past[0];
            do_past[0] = do_obs;
        end
    end

    // ----------------------------------------
    // Test steps
    // ----------------------------------------
    task automatic set_traffic(int cw_rate, int ccw_rate, int pe_rate, int ro_level);
        @(posedge clk);
        gen_rate[PORT_CW] = cw_rate;
        gen_rate[PORT_CCW] = ccw_rate;
        gen_rate[PORT_PE] = pe_rate;
        foreach (ro_rate[p]) begin
            ro_rate[p] = ro_level;
        end
    endtask

    task automatic drain_outputs();
        int waited;
        set_traffic(0, 0, 0, 4);
        waited = 0;
        while (waited < 100) begin
            @(negedge clk);
            if (pending_count() == 0) begin
                break;
            end
            waited++;
        end
        assert (pending_count() == 0) else begin
            $display("%0d packets never left the router", pending_count());
            error_count++;
        end
    endtask

    task automatic exits_reached(string what, int first, int second);
        assert (consumed[first] > 0 && consumed[second] > 0) else begin
            $display("%s traffic did not reach both %sdo and %sdo",
                what, port_name[first], port_name[second]);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        logic expected_polarity;
        repeat (4) begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                verify_level({port_name[p], "so"}, so_obs[p], 1'b0);
                verify_level({port_name[p], "ri"}, ri_obs[p], 1'b0);
            end
            verify_level("polarity", polarity, 1'b0);
        end
        reset = 1'b0;
        // Even in the first cycle after reset, then alternating
        expected_polarity = 1'b0;
        repeat (6) begin
            @(negedge clk);
            expected_polarity = !expected_polarity;
            verify_level("polarity", polarity, expected_polarity);
            for (int p = 0; p < NUM_PORTS; p++) begin
                verify_level({port_name[p], "so"}, so_obs[p], 1'b0);
                verify_level({port_name[p], "ri"}, ri_obs[p], 1'b1);
            end
        end
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_before);
        end
        foreach (consumed[p]) begin
            consumed[p] = 0;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int errors_before;
        int waited;
        reset = 1'b1;
        si_drv = '0;
        ro_drv = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            di_drv[p] = '0;
            gen_rate[p] = 0;
            ro_rate[p] = 0;
            consumed[p] = 0;
        end
        error_count = 0;
        test_count = 0;
        failed_tests = 0;

        errors_before = error_count;
        apply_reset();
        report_test("reset", errors_before);

        // Random hop LSB sends ring packets both onward and to pe
        errors_before = error_count;
        set_traffic(3, 0, 0, 4);
        repeat (60) @(posedge clk);
        drain_outputs();
        exits_reached("clockwise", PORT_CW, PORT_PE);
        report_test("clockwise traffic", errors_before);

        errors_before = error_count;
        set_traffic(0, 3, 0, 4);
        repeat (60) @(posedge clk);
        drain_outputs();
        exits_reached("counterclockwise", PORT_CCW, PORT_PE);
        report_test("counterclockwise traffic", errors_before);

        errors_before = error_count;
        set_traffic(0, 0, 3, 4);
        repeat (60) @(posedge clk);
        drain_outputs();
        exits_reached("injected", PORT_CW, PORT_CCW);
        report_test("injection", errors_before);

        // All receivers stalled until the inputs fill up
        errors_before = error_count;
        set_traffic(4, 4, 4, 0);
        @(negedge clk);
        waited = 0;
        while (ri_obs == '1 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        assert (ri_obs != '1) else begin
            $display("ri stayed high on every port with all receivers stalled");
            error_count++;
        end
        repeat (20) @(posedge clk);
        drain_outputs();
        report_test("back-pressure", errors_before);

        errors_before = error_count;
        set_traffic(2, 2, 2, 2);
        repeat (400) @(posedge clk);
        drain_outputs();
        report_test("random contention", errors_before);

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #200us;
        $display("simulation ran past its time limit");
        $display("sim failed");
        $finish;
    end

endmodule

//--- ring_router.f
+incdir+verification
design/ring_packet_pkg.sv
design/router_cfg_pkg.sv
design/port_link_if.sv
design/vc_buffer.sv
design/route_arbiter.sv
design/route_switch.sv
design/ring_router.sv
verification/ring_router_tb.sv
